/* project.f */
design/dispatch_pkg.sv
design/dispatch_control.sv
design/dispatch_read_seq.sv
design/tile_write_stage.sv
design/dispatcher_top.sv
bench/dispatcher_props.sv
bench/tb_dispatcher.sv

/* bench/tb_dispatcher.sv */
// Dispatcher testbench: clock, reset, buffer models, reference model, monitor, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_dispatcher;

    import dispatch_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_CMDS   = 40;
    localparam int BUF_DEPTH  = 1 << BUF_ADDR_W;

    typedef struct packed {
        logic                 right;
        logic [NUM_TILES-1:0] mask;
        tile_wr_t             wr;
    } exp_wr_t; // One expected tile write

    logic                 clk;
    logic                 reset_n;
    logic                 disp_en;
    disp_cmd_t            disp_cmd;
    logic                 disp_done;
    buf_rd_req_t          left_rd_req;
    buf_rd_req_t          right_rd_req;
    buf_rd_data_t         left_rd_data;
    buf_rd_data_t         right_rd_data;
    tile_wr_t             left_wr;
    tile_wr_t             right_wr;
    logic [NUM_TILES-1:0] tile_wr_mask;

    buf_rd_data_t mem_l [BUF_DEPTH]; // Left dispatcher buffer
    buf_rd_data_t mem_r [BUF_DEPTH]; // Right dispatcher buffer
    disp_cmd_t    cmds [NUM_CMDS];
    exp_wr_t      exp_q [$];

    integer seed = 32'hebf43e48;
    int     err_val;
    int     err_other;
    int     wr_seen;
    int     done_seen;
    int     wd_cycles;
    logic   cur_right; // Side of the command in flight

    dispatcher_top dut0 (
        .i_clk           (clk),
        .i_reset_n       (reset_n),
        .i_disp_en       (disp_en),
        .i_disp_cmd      (disp_cmd),
        .o_disp_done     (disp_done),
        .o_left_rd_req   (left_rd_req),
        .o_right_rd_req  (right_rd_req),
        .i_left_rd_data  (left_rd_data),
        .i_right_rd_data (right_rd_data),
        .o_left_wr       (left_wr),
        .o_right_wr      (right_wr),
        .o_tile_wr_mask  (tile_wr_mask)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Registered buffer reads, data one cycle after the request
    always @(posedge clk) begin
        if (left_rd_req.en) left_rd_data <= mem_l[left_rd_req.addr];
        if (right_rd_req.en) right_rd_data <= mem_r[right_rd_req.addr];
    end

    // ==============================
    // Stimulus and model
    // ==============================
    function automatic buf_rd_data_t rand_line();
        buf_rd_data_t d;
        for (int i = 0; i < 9; i++) begin
            d = {d[$bits(d)-33:0], 32'($random(seed))}; // Shift in 32 bits at a time
        end
        return d;
    endfunction

    function automatic disp_cmd_t rand_cmd();
        disp_cmd_t c;
        int        bs;
        int        mult;
        bs           = 1 + {$random(seed)} % 4;
        mult         = 1 + {$random(seed)} % 10;
        c.batch_size = CNT_W'(bs);
        c.nv_cnt     = CNT_W'(bs * mult + {$random(seed)} % bs); // Odd remainder at times
        c.tile_addr  = CMD_ADDR_W'($random(seed));              // Upper bits ignored
        c.tile_en    = NUM_TILES'($random(seed) & $random(seed) & $random(seed)); // Sparse
        if (c.tile_en == '0) begin
            c.tile_en[{$random(seed)} % NUM_TILES] = 1'b1;
        end
        c.right      = 1'($random(seed));
        c.broadcast  = 1'($random(seed));
        return c;
    endfunction

    // Expected writes of one command, in order
    task automatic build_expected(input disp_cmd_t c, output int n_wr);
        int           nt;
        int           bl;
        int           nb;
        int           src;
        int           dst;
        exp_wr_t      e;
        buf_rd_data_t d;
        nt   = $countones(c.tile_en);
        bl   = c.batch_size * LINES_PER_NV;
        nb   = c.nv_cnt / c.batch_size;
        n_wr = nb * bl;
        for (int p = 0; p < nb; p++) begin
            for (int ln = 0; ln < bl; ln++) begin
                if (c.broadcast) begin
                    src    = (p / nt) * bl + ln; // Same batch once per tile index
                    dst    = c.tile_addr + ln;   // Base never moves
                    e.mask = c.tile_en;
                end else begin
                    src    = p * bl + ln;
                    dst    = c.tile_addr + (p / nt) * bl + ln; // Next row after each wrap
                    e.mask = NUM_TILES'(1) << (p % nt);
                end
                d         = c.right ? mem_r[src % BUF_DEPTH] : mem_l[src % BUF_DEPTH];
                e.right   = c.right;
                e.wr.en   = 1'b1;
                e.wr.addr = TILE_ADDR_W'(dst);
                e.wr.man  = d.man;
                e.wr.exp  = d.exp;
                exp_q.push_back(e);
            end
        end
    endtask

    // ==============================
    // Compare tasks
    // ==============================
    task automatic write_compare(input string name, input tile_wr_t exp, input tile_wr_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            err_val++;
        end
    endtask

    task automatic mask_compare(input string name, input logic [NUM_TILES-1:0] exp,
                                input logic [NUM_TILES-1:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            err_val++;
        end
    endtask

    task automatic count_compare(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            err_val++;
        end
    endtask

    // Outputs stable mid-cycle
    always @(negedge clk) begin : monitor
        exp_wr_t e;
        if (left_wr.en || right_wr.en) begin
            wr_seen++;
            if (exp_q.size() == 0) begin
                $display("ERROR: tile write at %0t with no write expected", $time);
                err_other++;
            end else begin
                e = exp_q.pop_front();
                if (e.right ? left_wr.en : right_wr.en) begin
                    $display("ERROR: tile write on the wrong side at %0t", $time);
                    err_other++;
                end
                write_compare("tile write", e.wr, e.right ? right_wr : left_wr);
                mask_compare("tile mask", e.mask, tile_wr_mask);
            end
        end
        if (cur_right ? left_rd_req.en : right_rd_req.en) begin
            $display("ERROR: buffer read on the wrong side at %0t", $time);
            err_other++;
        end
        if (disp_done) done_seen++;
    end

    task automatic run_command(input disp_cmd_t c, input bit busy_strobe);
        int n_exp;
        int wr_base;
        int done_base;
        build_expected(c, n_exp);
        @(negedge clk);
        cur_right = c.right;
        wr_base   = wr_seen;
        done_base = done_seen;
        disp_cmd  = c;
        disp_en   = 1'b1;
        @(negedge clk);
        disp_en = 1'b0;
        if (busy_strobe) begin
            repeat (3) @(negedge clk);
            disp_cmd = rand_cmd(); // Must be ignored
            disp_en  = 1'b1;
            @(negedge clk);
            disp_en = 1'b0;
        end
        while (!disp_done) @(negedge clk);
        @(negedge clk);
        @(posedge clk); // Monitor has seen the cycle after done
        count_compare("writes per command", n_exp, wr_seen - wr_base);
        count_compare("done pulses", 1, done_seen - done_base);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int total;
        reset_n       = 1'b0;
        disp_en       = 1'b0;
        disp_cmd      = '0;
        left_rd_data  = '0;
        right_rd_data = '0;
        cur_right     = 1'b0;
        err_val       = 0;
        err_other     = 0;
        wr_seen       = 0;
        done_seen     = 0;
        total         = 200;
        for (int a = 0; a < BUF_DEPTH; a++) begin
            mem_l[a] = rand_line();
            mem_r[a] = rand_line();
        end
        for (int i = 0; i < NUM_CMDS; i++) begin
            cmds[i] = rand_cmd();
            total += (cmds[i].nv_cnt / cmds[i].batch_size) * cmds[i].batch_size
                     * LINES_PER_NV * $countones(cmds[i].tile_en) + 30;
        end
        wd_cycles = total;
        repeat (5) @(negedge clk);
        reset_n = 1'b1;
        repeat (10) begin
            @(negedge clk);
            if (left_wr.en || right_wr.en || left_rd_req.en || right_rd_req.en || disp_done) begin
                $display("ERROR: enable or done high before the first command at %0t", $time);
                err_other++;
            end
            mask_compare("idle mask", '0, tile_wr_mask);
        end
        for (int i = 0; i < NUM_CMDS; i++) begin
            run_command(cmds[i], (i % 3) == 1);
        end
        count_compare("leftover expected writes", 0, exp_q.size());
        if (dut0.u_wr_stage.u_props.fail_cnt != 0) begin
            $display("ERROR: %0d write stage assertions failed",
                     dut0.u_wr_stage.u_props.fail_cnt);
            err_other += dut0.u_wr_stage.u_props.fail_cnt;
        end
        $display("Errors: %0d value mismatches, %0d other failures", err_val, err_other);
        if (err_val + err_other == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog, limit known once commands exist
    initial begin : watchdog
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("ERROR: timeout after %0d cycles, dispatch did not finish", wd_cycles);
        $display("Errors: %0d value mismatches, %0d other failures", err_val, err_other);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/dispatcher_props.sv */
// Bound assertions on tile write enables, write mask and read-to-write timing
`timescale 1ns/1ps
`default_nettype none

module dispatcher_props (
    input logic                               i_clk,
    input logic                               i_reset_n,
    input dispatch_pkg::rd_beat_t             i_beat,     // Read request cycle
    input dispatch_pkg::tile_wr_t             i_left_wr,
    input dispatch_pkg::tile_wr_t             i_right_wr,
    input logic [dispatch_pkg::NUM_TILES-1:0] i_tile_wr_mask
);

    logic wr_any;
    int   fail_cnt = 0; // Failed assertions so far

    assign wr_any = i_left_wr.en || i_right_wr.en;

    // Mask only on write cycles
    mask_with_write: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (|i_tile_wr_mask) == wr_any)
        else begin
            $error("tile write mask and write enables disagree");
            fail_cnt++;
        end

    // One side for the whole burst of a command
    one_side: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        wr_any && $past(wr_any) |-> (i_right_wr.en == $past(i_right_wr.en)))
        else begin
            $error("tile write side changed within a burst");
            fail_cnt++;
        end

    // Buffer latency of one cycle
    read_then_write: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_beat.valid |=> wr_any)
        else begin
            $error("read request not followed by a tile write");
            fail_cnt++;
        end

    write_after_read: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        wr_any |-> $past(i_beat.valid))
        else begin
            $error("tile write without a read request one cycle before");
            fail_cnt++;
        end

endmodule

bind tile_write_stage dispatcher_props u_props (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_beat         (i_beat),
    .i_left_wr      (o_left_wr),
    .i_right_wr     (o_right_wr),
    .i_tile_wr_mask (o_tile_wr_mask)
);

`default_nettype wire

/* design/dispatcher_top.sv */
// Dispatcher top: control, read sequencer and tile write stage
`timescale 1ns/1ps
`default_nettype none

module dispatcher_top (
    input  logic                       i_clk,
    input  logic                       i_reset_n,

    // Command
    input  logic                       i_disp_en,
    input  dispatch_pkg::disp_cmd_t    i_disp_cmd,
    output logic                       o_disp_done,

    // Dispatcher buffer reads
    output dispatch_pkg::buf_rd_req_t  o_left_rd_req,
    output dispatch_pkg::buf_rd_req_t  o_right_rd_req,
    input  dispatch_pkg::buf_rd_data_t i_left_rd_data,
    input  dispatch_pkg::buf_rd_data_t i_right_rd_data,

    // Tile memory writes
    output dispatch_pkg::tile_wr_t     o_left_wr,
    output dispatch_pkg::tile_wr_t     o_right_wr,
    output logic [dispatch_pkg::NUM_TILES-1:0] o_tile_wr_mask
);

    import dispatch_pkg::*;

    disp_cfg_t cfg;        // Captured command
    rd_beat_t  beat;       // Read side to write side
    logic      start;
    logic      read_done;
    logic      wr_pending;

    // ==============================
    // Command FSM
    // ==============================
    dispatch_control u_ctrl (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_disp_en    (i_disp_en),
        .i_disp_cmd   (i_disp_cmd),
        .i_read_done  (read_done),
        .i_wr_pending (wr_pending),
        .o_cfg        (cfg),
        .o_start      (start),
        .o_disp_done  (o_disp_done)
    );

    // ==============================
    // Read sequencer
    // ==============================
    dispatch_read_seq u_rd_seq (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_start        (start),
        .i_cfg          (cfg),
        .o_left_rd_req  (o_left_rd_req),
        .o_right_rd_req (o_right_rd_req),
        .o_beat         (beat),
        .o_read_done    (read_done)
    );

    // ==============================
    // Write stage
    // ==============================
    tile_write_stage u_wr_stage (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_cfg           (cfg),
        .i_beat          (beat),
        .i_left_rd_data  (i_left_rd_data),
        .i_right_rd_data (i_right_rd_data),
        .o_left_wr       (o_left_wr),
        .o_right_wr      (o_right_wr),
        .o_tile_wr_mask  (o_tile_wr_mask),
        .o_wr_pending    (wr_pending)
    );

endmodule

`default_nettype wire

/* design/tile_write_stage.sv */
// Tile write stage: read latency alignment, side steering, tile write mask
`timescale 1ns/1ps
`default_nettype none

module tile_write_stage (
    input  logic                       i_clk,
    input  logic                       i_reset_n,
    input  dispatch_pkg::disp_cfg_t    i_cfg,
    input  dispatch_pkg::rd_beat_t     i_beat,
    input  dispatch_pkg::buf_rd_data_t i_left_rd_data,  // Registered buffer output
    input  dispatch_pkg::buf_rd_data_t i_right_rd_data,
    output dispatch_pkg::tile_wr_t     o_left_wr,
    output dispatch_pkg::tile_wr_t     o_right_wr,
    output logic [dispatch_pkg::NUM_TILES-1:0] o_tile_wr_mask,
    output logic                       o_wr_pending
);

    import dispatch_pkg::*;

    logic                   wr_valid;    // Beat delayed by buffer latency
    logic [TILE_IDX_W-1:0]  wr_tile_idx;
    logic [TILE_ADDR_W-1:0] wr_addr;
    logic [NUM_TILES-1:0]   onehot;

    // ==============================
    // One-cycle alignment
    // ==============================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= i_beat.valid;
        end
    end

    // Payload follows valid
    always_ff @(posedge i_clk) begin
        wr_tile_idx <= i_beat.tile_idx;
        wr_addr     <= i_beat.dst_addr;
    end

    assign o_wr_pending = wr_valid;

    // ==============================
    // Side steering
    // ==============================
    assign o_left_wr.en   = wr_valid && !i_cfg.right;
    assign o_left_wr.addr = wr_addr;
    assign o_left_wr.man  = i_left_rd_data.man;  // Pass through
    assign o_left_wr.exp  = i_left_rd_data.exp;

    assign o_right_wr.en   = wr_valid && i_cfg.right;
    assign o_right_wr.addr = wr_addr;
    assign o_right_wr.man  = i_right_rd_data.man;
    assign o_right_wr.exp  = i_right_rd_data.exp;

    // ==============================
    // Tile write mask
    // ==============================
    assign onehot = NUM_TILES'(1) << wr_tile_idx;

    always_comb begin
        o_tile_wr_mask = '0; // No write, no tiles
        if (wr_valid) begin
            if (i_cfg.broadcast) begin
                o_tile_wr_mask = i_cfg.tile_en; // Every enabled tile at once
            end else begin
                o_tile_wr_mask = onehot;
            end
        end
    end

endmodule

`default_nettype wire

/* design/dispatch_read_seq.sv */
// Dispatch read sequencer: source address, tile index, destination and batch counters
`timescale 1ns/1ps
`default_nettype none

module dispatch_read_seq (
    input  logic                      i_clk,
    input  logic                      i_reset_n,
    input  logic                      i_start,     // Load counters
    input  dispatch_pkg::disp_cfg_t   i_cfg,
    output dispatch_pkg::buf_rd_req_t o_left_rd_req,
    output dispatch_pkg::buf_rd_req_t o_right_rd_req,
    output dispatch_pkg::rd_beat_t    o_beat,
    output logic                      o_read_done  // Held until next start
);

    import dispatch_pkg::*;

    logic [BUF_ADDR_W-1:0]  src_addr;  // Dispatcher buffer read address
    logic [TILE_IDX_W-1:0]  tile_idx;  // Tile of the current batch
    logic [TILE_ADDR_W-1:0] dst_base;  // Destination of line 0 of the batch
    logic [LINE_CNT_W-1:0]  line_cnt;  // Line within batch
    logic [CNT_W-1:0]       batch_cnt; // Batch passes so far
    logic                   active;    // Requests issued while high

    logic                   batch_end;
    logic                   tile_wrap;
    logic                   last_batch;
    logic [LINE_CNT_W-1:0]  lines_m1;

    // ==============================
    // Batch boundaries
    // ==============================
    assign lines_m1   = i_cfg.batch_lines - LINE_CNT_W'(1);
    assign batch_end  = (line_cnt == lines_m1);
    assign tile_wrap  = (CNT_W'(tile_idx) == i_cfg.num_tiles - CNT_W'(1));
    assign last_batch = (batch_cnt == i_cfg.total_batches - CNT_W'(1));

    // Run and done flags
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            active      <= 1'b0;
            o_read_done <= 1'b0;
        end else if (i_start) begin
            active      <= 1'b1;
            o_read_done <= 1'b0;
        end else if (active && batch_end && last_batch) begin
            active      <= 1'b0; // Last request was this cycle
            o_read_done <= 1'b1;
        end
    end

    // ==============================
    // Address and index counters
    // ==============================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            src_addr  <= '0;
            tile_idx  <= '0;
            dst_base  <= '0;
            line_cnt  <= '0;
            batch_cnt <= '0;
        end else if (i_start) begin
            src_addr  <= '0;
            tile_idx  <= '0;
            dst_base  <= i_cfg.tile_addr; // From the command just accepted
            line_cnt  <= '0;
            batch_cnt <= '0;
        end else if (active) begin
            src_addr <= src_addr + BUF_ADDR_W'(1); // Sequential by default
            line_cnt <= line_cnt + LINE_CNT_W'(1);
            if (batch_end) begin
                line_cnt  <= '0;
                batch_cnt <= batch_cnt + CNT_W'(1);
                if (tile_wrap) begin
                    tile_idx <= '0;
                    if (!i_cfg.broadcast) begin
                        // Distribute: every tile has had a batch, move down
                        dst_base <= dst_base + i_cfg.batch_lines[TILE_ADDR_W-1:0];
                    end
                end else begin
                    tile_idx <= tile_idx + TILE_IDX_W'(1);
                    if (i_cfg.broadcast) begin
                        // Broadcast: replay the same batch for the next tile
                        src_addr <= src_addr - lines_m1[BUF_ADDR_W-1:0];
                    end
                end
            end
        end
    end

    // ==============================
    // Outputs
    // ==============================
    assign o_left_rd_req.en   = active && !i_cfg.right;
    assign o_left_rd_req.addr = src_addr;
    assign o_right_rd_req.en   = active && i_cfg.right;
    assign o_right_rd_req.addr = src_addr;

    assign o_beat.valid    = active;
    assign o_beat.tile_idx = tile_idx;
    assign o_beat.dst_addr = dst_base + line_cnt[TILE_ADDR_W-1:0]; // Wraps

endmodule

`default_nettype wire

/* design/dispatch_control.sv */
// Dispatch command capture, derived parameters and idle/busy/done FSM
`timescale 1ns/1ps
`default_nettype none

module dispatch_control (
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    input  logic                    i_disp_en,    // One-cycle strobe
    input  dispatch_pkg::disp_cmd_t i_disp_cmd,
    input  logic                    i_read_done,  // Level from read sequencer
    input  logic                    i_wr_pending, // Write stage still holds a beat
    output dispatch_pkg::disp_cfg_t o_cfg,
    output logic                    o_start,      // Pulse, cycle after acceptance
    output logic                    o_disp_done
);

    import dispatch_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_BUSY = 2'd1,
        ST_DONE = 2'd2
    } state_t;

    state_t state_q, state_d;
    logic   accept;

    // Number of set bits in the tile mask
    function automatic logic [CNT_W-1:0] popcount(input logic [NUM_TILES-1:0] bits);
        logic [CNT_W-1:0] cnt;
        cnt = '0;
        for (int i = 0; i < NUM_TILES; i++) begin
            cnt = cnt + CNT_W'(bits[i]);
        end
        return cnt;
    endfunction

    assign accept = (state_q == ST_IDLE) && i_disp_en; // Busy strobes are dropped

    // ==============================
    // FSM
    // ==============================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_BUSY;
                end
            end
            ST_BUSY: begin
                // Read done is stale while start is high
                if (!o_start && i_read_done && !i_wr_pending) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: state_d = ST_IDLE; // Single cycle
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state_q <= ST_IDLE;
            o_start <= 1'b0;
        end else begin
            state_q <= state_d;
            o_start <= accept;
        end
    end

    // ==============================
    // Command capture
    // ==============================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_cfg <= '0;
        end else if (accept) begin
            o_cfg.tile_en     <= i_disp_cmd.tile_en;
            o_cfg.right       <= i_disp_cmd.right;
            o_cfg.broadcast   <= i_disp_cmd.broadcast;
            o_cfg.tile_addr   <= i_disp_cmd.tile_addr[TILE_ADDR_W-1:0]; // Low bits only
            o_cfg.num_tiles   <= popcount(i_disp_cmd.tile_en);
            o_cfg.batch_lines <= LINE_CNT_W'(i_disp_cmd.batch_size)
                                 * LINE_CNT_W'(LINES_PER_NV);
            // Integer division, remainder vectors are not sent
            o_cfg.total_batches <= i_disp_cmd.nv_cnt / i_disp_cmd.batch_size;
        end
    end

    assign o_disp_done = (state_q == ST_DONE);

endmodule

`default_nettype wire

/* design/dispatch_pkg.sv */
// Dispatcher widths, command and configuration structs, buffer and tile port structs
`default_nettype none

package dispatch_pkg;

    // ==============================
    // Widths and sizes
    // ==============================
    localparam int NUM_TILES    = 24;  // Tiles in the enable mask
    localparam int TILE_IDX_W   = 5;   // Tile index width
    localparam int BUF_ADDR_W   = 9;   // Dispatcher buffer address, wraps
    localparam int TILE_ADDR_W  = 9;   // Tile memory address, wraps
    localparam int MAN_W        = 256; // Mantissa line
    localparam int EXP_W        = 8;   // Exponent
    localparam int LINES_PER_NV = 4;   // Lines per native vector
    localparam int LINE_CNT_W   = 10;  // Line counter, holds batch lines
    localparam int CNT_W        = 8;   // Vector count and batch size fields
    localparam int CMD_ADDR_W   = 16;  // Tile address field in the command

    // ==============================
    // Command and configuration
    // ==============================
    // Command as presented with i_disp_en
    typedef struct packed {
        logic [CNT_W-1:0]      nv_cnt;     // Native vectors to move
        logic [CNT_W-1:0]      batch_size; // Native vectors per batch
        logic [CMD_ADDR_W-1:0] tile_addr;  // Only low TILE_ADDR_W bits used
        logic [NUM_TILES-1:0]  tile_en;    // Enabled tiles
        logic                  right;      // 1 = right side
        logic                  broadcast;  // 1 = broadcast, 0 = distribute
    } disp_cmd_t;

    // Captured command plus derived values
    typedef struct packed {
        logic [NUM_TILES-1:0]   tile_en;
        logic                   right;
        logic                   broadcast;
        logic [TILE_ADDR_W-1:0] tile_addr;     // Start destination
        logic [CNT_W-1:0]       num_tiles;     // Popcount of tile_en
        logic [LINE_CNT_W-1:0]  batch_lines;   // batch_size * LINES_PER_NV
        logic [CNT_W-1:0]       total_batches; // nv_cnt / batch_size
    } disp_cfg_t;

    // ==============================
    // Memory ports
    // ==============================
    typedef struct packed {
        logic                  en;
        logic [BUF_ADDR_W-1:0] addr;
    } buf_rd_req_t;

    typedef struct packed {
        logic [MAN_W-1:0] man;
        logic [EXP_W-1:0] exp;
    } buf_rd_data_t;

    typedef struct packed {
        logic                   en;
        logic [TILE_ADDR_W-1:0] addr;
        logic [MAN_W-1:0]       man;
        logic [EXP_W-1:0]       exp;
    } tile_wr_t;

    // Read sequencer to write stage, one per read request
    typedef struct packed {
        logic                   valid;
        logic [TILE_IDX_W-1:0]  tile_idx;
        logic [TILE_ADDR_W-1:0] dst_addr;
    } rd_beat_t;

endpackage

`default_nettype wire
